// File: axi_fetch.sv
`default_nettype none

module axi_fetch
    import axi_pkg::*;
(
    input  wire                     clock,
    input  wire                     reset,            // async, active low

    fetch_bus_if.responder          bus,

    // read address channel
    output logic                    axi_ar_valid_o,
    output logic [AXI_ADDR_W-1:0]   axi_ar_addr_o,
    output logic [AXI_LEN_W-1:0]    axi_ar_len_o,
    output logic [AXI_SIZE_W-1:0]   axi_ar_size_o,
    output logic [AXI_BURST_W-1:0]  axi_ar_burst_o,
    output logic [AXI_PROT_W-1:0]   axi_ar_prot_o,
    output logic [AXI_CACHE_W-1:0]  axi_ar_cache_o,
    output logic [AXI_ID_W-1:0]     axi_ar_id_o,
    input  wire                     axi_ar_ready_i,

    // read data channel
    output logic                    axi_r_ready_o,
    input  wire                     axi_r_valid_i,
    input  wire  [AXI_DATA_W-1:0]   axi_r_data_i,
    input  wire  [AXI_RESP_W-1:0]   axi_r_resp_i,
    input  wire                     axi_r_last_i
);

    logic [FETCH_ST_W-1:0]   state_q;
    logic [FETCH_ST_W-1:0]   state_d;

    logic [AXI_ADDR_W-1:3]   blk_q;      // held block address, 8-byte aligned
    logic [AXI_DATA_W-1:0]   data_q;     // held block contents
    logic                    err_q;      // held block had a bad resp

    logic                    hit;        // request falls in the held block
    logic                    capture;    // latch a new block address
    logic                    beat_done;  // last read beat accepted

    assign hit       = (bus.addr[AXI_ADDR_W-1:3] == blk_q);
    assign beat_done = (state_q == FETCH_R_WAIT) && axi_r_valid_i && axi_r_last_i;

    // next state
    always_comb begin
        state_d = state_q;
        capture = 1'b0;
        case (state_q)
            FETCH_IDLE: begin
                if (bus.req) begin
                    state_d = FETCH_AR_WAIT;
                    capture = 1'b1;
                end
            end
            FETCH_AR_WAIT: begin
                if (axi_ar_ready_i) begin     // address accepted
                    state_d = FETCH_R_WAIT;
                end
            end
            FETCH_R_WAIT: begin
                if (beat_done) begin
                    state_d = FETCH_DONE;
                end
            end
            FETCH_DONE: begin
                if (!bus.req) begin
                    state_d = FETCH_IDLE;     // stall drops the held block
                end else if (!hit) begin
                    state_d = FETCH_AR_WAIT;  // sequential cross or redirect
                    capture = 1'b1;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // block address, stable from ar_wait until the next capture
    always_ff @(posedge clock) begin
        if (capture) begin
            blk_q <= bus.addr[AXI_ADDR_W-1:3];
        end
    end

    // read payload
    always_ff @(posedge clock) begin
        if (beat_done) begin
            data_q <= axi_r_data_i;
            err_q  <= (axi_r_resp_i != AXI_RESP_OKAY);  // slverr or decerr
        end
    end

    // ack in the same cycle as a hitting req
    assign bus.ack  = (state_q == FETCH_DONE) && bus.req && hit;
    assign bus.data = data_q;
    assign bus.err  = err_q;

    // AR channel, address from the register so it holds until arready
    assign axi_ar_valid_o = (state_q == FETCH_AR_WAIT);
    assign axi_ar_addr_o  = {blk_q, 3'b000};
    assign axi_ar_len_o   = AXI_LEN_SINGLE;      // one beat
    assign axi_ar_size_o  = AXI_SIZE_8B;
    assign axi_ar_burst_o = AXI_BURST_INCR;
    assign axi_ar_prot_o  = AXI_PROT_INSTR;
    assign axi_ar_cache_o = AXI_CACHE_NONCACHE;
    assign axi_ar_id_o    = AXI_ID_FETCH;

    // R channel, only after the address went out
    assign axi_r_ready_o  = (state_q == FETCH_R_WAIT);

endmodule

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

    // bus widths
    localparam int AXI_ADDR_W  = 64;
    localparam int AXI_DATA_W  = 64;
    localparam int AXI_ID_W    = 4;

    // field widths of the read address and read data channels
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_PROT_W  = 3;
    localparam int AXI_CACHE_W = 4;
    localparam int AXI_RESP_W  = 2;

    // fixed AR field values, one beat per read
    localparam logic [AXI_LEN_W-1:0]   AXI_LEN_SINGLE     = 8'd0;    // beats minus one
    localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_8B        = 3'b011;  // 2**3 bytes
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR     = 2'b01;
    localparam logic [AXI_PROT_W-1:0]  AXI_PROT_INSTR     = 3'b100;  // unpriv, secure, instr
    localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_NONCACHE = 4'b0010; // normal, no alloc
    localparam logic [AXI_ID_W-1:0]    AXI_ID_FETCH       = 4'h0;    // single id, in order

    // read response codes
    localparam logic [AXI_RESP_W-1:0]  AXI_RESP_OKAY      = 2'b00;

    // read master state codes, gray ordered as idle, ar, r, done
    localparam int FETCH_ST_W = 2;
    localparam logic [FETCH_ST_W-1:0] FETCH_IDLE    = 2'b00;
    localparam logic [FETCH_ST_W-1:0] FETCH_AR_WAIT = 2'b01;
    localparam logic [FETCH_ST_W-1:0] FETCH_R_WAIT  = 2'b11;
    localparam logic [FETCH_ST_W-1:0] FETCH_DONE    = 2'b10;

endpackage

`default_nettype wire

// File: fetch_bus_if.sv
`default_nettype none

interface fetch_bus_if
    import rv_pkg::*, axi_pkg::*;
();

    logic                  req;   // level, held until ack
    logic [XLEN-1:0]       addr;  // byte address of the wanted instruction
    logic                  ack;   // one cycle pulse, data valid with it
    logic [AXI_DATA_W-1:0] data;  // whole aligned 8-byte block
    logic                  err;   // block came back with a bad response

    // pc stage
    modport requester (output req, addr);

    // fetch stage
    modport responder (input req, addr, output ack, data, err);

    // predecode only listens
    modport monitor (input req, addr, ack, data, err);

endinterface

`default_nettype wire

// File: fetch_props.sv
`default_nettype none

module fetch_props
    import axi_pkg::*;
(
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   ar_valid_i,
    input  wire                   ar_ready_i,
    input  wire [AXI_ADDR_W-1:0]  ar_addr_i,
    input  wire                   r_ready_i,
    input  wire                   ack_i       // fetch bus ack
);

    // AR must hold valid and address until the slave takes it
    property ar_held_until_ready;
        @(posedge clock) disable iff (!reset)
        (ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_addr_i));
    endproperty

    // one beat in flight at a time, no rready with an address pending
    property r_ready_after_ar;
        @(posedge clock) disable iff (!reset)
        r_ready_i |-> !ar_valid_i;
    endproperty

    // ack only from a held block, never while fetching
    property no_ack_during_ar;
        @(posedge clock) disable iff (!reset)
        ack_i |-> !ar_valid_i;
    endproperty

    ar_stable_chk: assert property (ar_held_until_ready)
        else $error("arvalid or araddr changed before arready");

    r_ready_chk: assert property (r_ready_after_ar)
        else $error("rready high while an AR request is pending");

    ack_chk: assert property (no_ack_during_ar)
        else $error("fetch ack in a cycle with arvalid high");

endmodule

`default_nettype wire

// File: fetch_top.sv
`default_nettype none

module fetch_top
    import rv_pkg::*, axi_pkg::*;
(
    input  wire                     clock,
    input  wire                     reset,

    // pipeline control
    input  wire                     stall_i,
    input  wire                     redirect_valid_i,
    input  wire  [XLEN-1:0]         redirect_pc_i,

    // AXI read address channel
    output logic                    axi_ar_valid_o,
    output logic [AXI_ADDR_W-1:0]   axi_ar_addr_o,
    output logic [AXI_LEN_W-1:0]    axi_ar_len_o,
    output logic [AXI_SIZE_W-1:0]   axi_ar_size_o,
    output logic [AXI_BURST_W-1:0]  axi_ar_burst_o,
    output logic [AXI_PROT_W-1:0]   axi_ar_prot_o,
    output logic [AXI_CACHE_W-1:0]  axi_ar_cache_o,
    output logic [AXI_ID_W-1:0]     axi_ar_id_o,
    input  wire                     axi_ar_ready_i,

    // AXI read data channel
    output logic                    axi_r_ready_o,
    input  wire                     axi_r_valid_i,
    input  wire  [AXI_DATA_W-1:0]   axi_r_data_i,
    input  wire  [AXI_RESP_W-1:0]   axi_r_resp_i,
    input  wire                     axi_r_last_i,

    // decoded instruction out
    output logic                    inst_valid_o,
    output logic [XLEN-1:0]         inst_pc_o,
    output logic [ILEN-1:0]         inst_o,
    output logic [REG_ADDR_W-1:0]   inst_rd_o,
    output logic [XLEN-1:0]         inst_imm_o,
    output logic                    inst_err_o
);

    fetch_bus_if bus_if ();  // pc -> fetch -> predecode

    pc_gen pc_gen_i (
        .clock            (clock),
        .reset            (reset),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .bus              (bus_if.requester),
        .ack_i            (bus_if.ack)        // requester modport has no ack
    );

    axi_fetch axi_fetch_i (
        .clock            (clock),
        .reset            (reset),
        .bus              (bus_if.responder),
        .axi_ar_valid_o   (axi_ar_valid_o),
        .axi_ar_addr_o    (axi_ar_addr_o),
        .axi_ar_len_o     (axi_ar_len_o),
        .axi_ar_size_o    (axi_ar_size_o),
        .axi_ar_burst_o   (axi_ar_burst_o),
        .axi_ar_prot_o    (axi_ar_prot_o),
        .axi_ar_cache_o   (axi_ar_cache_o),
        .axi_ar_id_o      (axi_ar_id_o),
        .axi_ar_ready_i   (axi_ar_ready_i),
        .axi_r_ready_o    (axi_r_ready_o),
        .axi_r_valid_i    (axi_r_valid_i),
        .axi_r_data_i     (axi_r_data_i),
        .axi_r_resp_i     (axi_r_resp_i),
        .axi_r_last_i     (axi_r_last_i)
    );

    inst_predecode inst_predecode_i (
        .clock            (clock),
        .reset            (reset),
        .bus              (bus_if.monitor),
        .stall_i          (stall_i),
        .inst_valid_o     (inst_valid_o),
        .inst_pc_o        (inst_pc_o),
        .inst_o           (inst_o),
        .inst_rd_o        (inst_rd_o),
        .inst_imm_o       (inst_imm_o),
        .inst_err_o       (inst_err_o)
    );

endmodule

`default_nettype wire

// File: inst_predecode.sv
`default_nettype none

module inst_predecode
    import rv_pkg::*;
(
    input  wire                    clock,
    input  wire                    reset,         // async, active low

    fetch_bus_if.monitor           bus,
    input  wire                    stall_i,

    output logic                   inst_valid_o,  // one cycle after ack
    output logic [XLEN-1:0]        inst_pc_o,
    output logic [ILEN-1:0]        inst_o,
    output logic [REG_ADDR_W-1:0]  inst_rd_o,
    output logic [XLEN-1:0]        inst_imm_o,
    output logic                   inst_err_o
);

    inst_word_t       word;     // selected half of the block
    logic [XLEN-1:0]  imm_i;    // I immediate, sign extended
    logic [XLEN-1:0]  imm_s;    // S immediate, sign extended
    logic             is_store;

    // bit 2 picks the upper word, little endian block
    assign word.raw = bus.addr[2] ? bus.data[2*ILEN-1:ILEN] : bus.data[ILEN-1:0];

    assign is_store = (word.itype.opcode == OPC_STORE);

    assign imm_i = {{(XLEN-12){word.itype.imm[11]}}, word.itype.imm};
    assign imm_s = {{(XLEN-12){word.stype.imm_hi[6]}},
                    word.stype.imm_hi,
                    word.stype.imm_lo};

    // valid flag
    // stall keeps it low, ack cannot come then anyway
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= bus.ack & ~stall_i;
        end
    end

    // payload, loaded only on ack and held otherwise
    always_ff @(posedge clock) begin
        if (bus.ack) begin
            inst_pc_o  <= bus.addr;         // pc as requested, not redirected
            inst_o     <= word.raw;
            inst_rd_o  <= word.itype.rd;    // rd bits also for stores, unused there
            inst_imm_o <= is_store ? imm_s : imm_i;
            inst_err_o <= bus.err;          // whole block shares one resp
        end
    end

endmodule

`default_nettype wire

// File: pc_gen.sv
`default_nettype none

module pc_gen
    import rv_pkg::*;
(
    input  wire             clock,
    input  wire             reset,             // async, active low

    input  wire             stall_i,           // downstream not ready
    input  wire             redirect_valid_i,  // jump taken somewhere later
    input  wire [XLEN-1:0]  redirect_pc_i,

    fetch_bus_if.requester  bus,
    input  wire             ack_i              // bus ack, routed by the top
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;

    // next pc
    // redirect wins over the sequential step
    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (ack_i) begin
            pc_d = pc_q + XLEN'(4);  // 32-bit instructions only
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // request is a level
    // the fetch stage sees the new pc one cycle after an ack
    assign bus.req  = ~stall_i;
    assign bus.addr = pc_q;   // old pc still valid in the redirect cycle

endmodule

`default_nettype wire

// File: project.f
axi_pkg.sv
rv_pkg.sv
fetch_bus_if.sv
pc_gen.sv
axi_fetch.sv
inst_predecode.sv
fetch_top.sv
fetch_props.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch -f project.f \
    -o sim_fetch > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // core widths
    localparam int XLEN       = 64;  // pc and immediate width
    localparam int ILEN       = 32;  // no compressed instructions
    localparam int REG_ADDR_W = 5;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;  // only one with S immediate here

    // I layout: imm[11:0] rs1 funct3 rd opcode
    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    // S layout: imm[11:5] rs2 rs1 funct3 imm[4:0] opcode
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } inst_s_t;

    // one instruction word, two readings
    // opcode sits in the same bits in both
    typedef union packed {
        inst_i_t         itype;
        inst_s_t         stype;
        logic [ILEN-1:0] raw;    // as fetched
    } inst_word_t;

endpackage

`default_nettype wire

// File: tb_fetch.sv
`default_nettype none

module tb_fetch
    import rv_pkg::*, axi_pkg::*;
();

    localparam logic [1:0]      RESP_SLVERR = 2'b10;
    localparam logic [XLEN-1:0] ERR_ADDR    = RESET_PC + 64'h200;  // the one bad block
    localparam int EXP_INSTS = 16 + 6 + 8 + 10 + 4;  // stream, redirect, error, stall, tail
    localparam int TIMEOUT   = 40 * EXP_INSTS;

    // len, size, burst, prot and cache as AXI4 encodes a single 8-byte instruction read
    localparam logic [19:0] AR_FIELDS_EXP = {8'h00, 3'b011, 2'b01, 3'b100, 4'b0010};

    logic clock, reset, stall_i, redirect_valid_i;
    logic [XLEN-1:0] redirect_pc_i;
    logic axi_ar_valid_o, axi_ar_ready_i, axi_r_ready_o, axi_r_valid_i, axi_r_last_i;
    logic [AXI_ADDR_W-1:0] axi_ar_addr_o;
    logic [AXI_LEN_W-1:0] axi_ar_len_o;
    logic [AXI_SIZE_W-1:0] axi_ar_size_o;
    logic [AXI_BURST_W-1:0] axi_ar_burst_o;
    logic [AXI_PROT_W-1:0] axi_ar_prot_o;
    logic [AXI_CACHE_W-1:0] axi_ar_cache_o;
    logic [AXI_ID_W-1:0] axi_ar_id_o;
    logic [AXI_ID_W-1:0] last_id;          // id of the previous AR handshake
    logic [AXI_DATA_W-1:0] axi_r_data_i;
    logic [AXI_RESP_W-1:0] axi_r_resp_i;
    logic inst_valid_o, inst_err_o;
    logic [XLEN-1:0] inst_pc_o, inst_imm_o, exp_pc, redir_tgt, last_ar;
    logic [ILEN-1:0] inst_o;
    logic [REG_ADDR_W-1:0] inst_rd_o;
    logic redir_seen, stream_phase;
    int err_count = 0;
    int delivered = 0;
    int ar_reads = 0;
    int cycles = 0;

    fetch_top dut_i (.*);

    bind axi_fetch fetch_props props_i (
        .clock(clock), .reset(reset), .ar_valid_i(axi_ar_valid_o),
        .ar_ready_i(axi_ar_ready_i), .ar_addr_i(axi_ar_addr_o),
        .r_ready_i(axi_r_ready_o), .ack_i(bus.ack)
    );

    // memory word is a hash of the full address with stores on odd words
    function automatic logic [ILEN-1:0] mem_word(input logic [XLEN-1:0] a);
        logic [31:0] h;
        h = (a[31:0] ^ a[63:32]) * 32'h9e37_79b1;
        h = h ^ {h[15:0], h[31:16]};
        mem_word = {h[31:7], (a[2] ? OPC_STORE : OPC_OP_IMM)};
    endfunction

    // immediate straight from the RISC-V field positions
    function automatic logic [XLEN-1:0] exp_imm(input logic [ILEN-1:0] w);
        if (w[6:0] == OPC_STORE) begin
            exp_imm = {{52{w[31]}}, w[31:25], w[11:7]};  // S layout
        end else begin
            exp_imm = {{52{w[31]}}, w[31:20]};           // I layout
        end
    endfunction

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // reference pc model where a redirect applies after the ack of its own cycle
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            exp_pc     <= RESET_PC;
            redir_seen <= 1'b0;
            redir_tgt  <= '0;
            last_ar    <= RESET_PC - 64'd8;  // first read is the reset block
            last_id    <= '0;
        end else begin
            if (redir_seen) begin
                exp_pc <= redir_tgt;
            end else if (inst_valid_o) begin
                exp_pc <= exp_pc + 64'd4;
            end
            if (inst_valid_o) delivered <= delivered + 1;
            redir_seen <= redirect_valid_i;
            redir_tgt  <= redirect_pc_i;
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                last_ar  <= axi_ar_addr_o;
                last_id  <= axi_ar_id_o;
                ar_reads <= ar_reads + 1;
            end
        end
    end

    pc_chk: assert property (@(posedge clock) disable iff (!reset)
        inst_valid_o |-> inst_pc_o == exp_pc)
        else begin
            err_count++;
            $display("mismatch at %0t: inst_pc_o got %h expected %h",
                     $time, $sampled(inst_pc_o), $sampled(exp_pc));
        end

    inst_chk: assert property (@(posedge clock) disable iff (!reset)
        inst_valid_o |-> inst_o == mem_word(inst_pc_o))
        else begin
            err_count++;
            $display("mismatch at %0t: inst_o got %h expected %h",
                     $time, $sampled(inst_o), mem_word($sampled(inst_pc_o)));
        end

    rd_chk: assert property (@(posedge clock) disable iff (!reset)
        inst_valid_o |-> inst_rd_o == inst_o[11:7])
        else begin
            err_count++;
            $display("mismatch at %0t: inst_rd_o got %h expected %h",
                     $time, $sampled(inst_rd_o), $sampled(inst_o[11:7]));
        end

    imm_chk: assert property (@(posedge clock) disable iff (!reset)
        inst_valid_o |-> inst_imm_o == exp_imm(inst_o))
        else begin
            err_count++;
            $display("mismatch at %0t: inst_imm_o got %h expected %h",
                     $time, $sampled(inst_imm_o), exp_imm($sampled(inst_o)));
        end

    err_chk: assert property (@(posedge clock) disable iff (!reset)
        inst_valid_o |-> inst_err_o == (inst_pc_o[63:3] == ERR_ADDR[63:3]))
        else begin
            err_count++;
            $display("mismatch at %0t: inst_err_o got %b expected %b", $time,
                     $sampled(inst_err_o), $sampled(inst_pc_o[63:3]) == ERR_ADDR[63:3]);
        end

    stall_chk: assert property (@(posedge clock) disable iff (!reset)
        stall_i |=> !inst_valid_o)
        else begin
            err_count++;
            $display("instruction delivered at %0t right after a stall cycle", $time);
        end

    // plain streaming reads each block once and in order
    blk_chk: assert property (@(posedge clock) disable iff (!reset)
        (stream_phase && axi_ar_valid_o && axi_ar_ready_i) |-> axi_ar_addr_o == last_ar + 64'd8)
        else begin
            err_count++;
            $display("mismatch at %0t: axi_ar_addr_o got %h expected %h",
                     $time, $sampled(axi_ar_addr_o), $sampled(last_ar) + 64'd8);
        end

    ar_field_chk: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o |-> {axi_ar_len_o, axi_ar_size_o, axi_ar_burst_o, axi_ar_prot_o,
                            axi_ar_cache_o} == AR_FIELDS_EXP)
        else begin
            err_count++;
            $display("mismatch at %0t: axi_ar len,size,burst,prot,cache got %h expected %h",
                     $time, $sampled({axi_ar_len_o, axi_ar_size_o, axi_ar_burst_o,
                                      axi_ar_prot_o, axi_ar_cache_o}), AR_FIELDS_EXP);
        end

    // the model has no rid and answers in order, so every read carries one id
    ar_id_chk: assert property (@(posedge clock) disable iff (!reset)
        (axi_ar_valid_o && ar_reads > 0) |-> axi_ar_id_o == last_id)
        else begin
            err_count++;
            $display("mismatch at %0t: axi_ar_id_o got %h expected %h",
                     $time, $sampled(axi_ar_id_o), $sampled(last_id));
        end

    // AXI slave with random arready and rvalid delays and one beat per read
    initial begin : axi_slave
        int unsigned d;
        logic [XLEN-1:0] blk;
        logic taken;
        axi_ar_ready_i = 1'b0;
        axi_r_valid_i  = 1'b0;
        axi_r_data_i   = '0;
        axi_r_resp_i   = AXI_RESP_OKAY;
        axi_r_last_i   = 1'b0;
        forever begin
            @(negedge clock);
            if (reset && axi_ar_valid_o) begin
                d = $urandom % 4;
                repeat (d) @(negedge clock);
                blk = axi_ar_addr_o;
                axi_ar_ready_i = 1'b1;        // taken at the next rising edge
                @(negedge clock);
                axi_ar_ready_i = 1'b0;
                d = $urandom % 4;
                repeat (d) @(negedge clock);
                axi_r_valid_i = 1'b1;
                axi_r_data_i  = {mem_word(blk + 64'd4), mem_word(blk)};  // upper word at +4
                axi_r_resp_i  = (blk[63:3] == ERR_ADDR[63:3]) ? RESP_SLVERR : AXI_RESP_OKAY;
                axi_r_last_i  = 1'b1;
                do begin
                    taken = axi_r_ready_o;
                    @(negedge clock);
                end while (!taken);
                axi_r_valid_i = 1'b0;
                axi_r_last_i  = 1'b0;
            end
        end
    end

    // hard stop on a hang
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout after %0d cycles with %0d instructions", cycles, delivered);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic wait_insts(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(negedge clock);
    endtask

    task automatic pulse_redirect(input logic [XLEN-1:0] tgt);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = tgt;
        @(negedge clock);
        redirect_valid_i = 1'b0;   // one cycle only
    endtask

    initial begin : stimulus
        int unsigned k;
        void'($urandom(32'h0b13_797f));
        reset = 1'b0;
        stall_i = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        stream_phase = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b1;
        wait_insts(16);                  // sequential stream over 8 blocks
        stream_phase = 1'b0;
        for (int i = 0; i < 6; i++) begin
            repeat ($urandom % 8) @(negedge clock);
            if (i % 2 == 0) begin
                pulse_redirect(RESET_PC + 64'h100 * (i + 1) + 64'd4 * (i % 4));  // far
            end else begin
                pulse_redirect({inst_pc_o[63:3], 3'b000});  // last delivered block
            end
            wait_insts(1);
        end
        pulse_redirect(ERR_ADDR - 64'd8);  // run through the error block
        wait_insts(8);
        for (int i = 0; i < 10; i++) begin
            k = 1 + $urandom % 4;
            stall_i = 1'b1;
            repeat (k) @(negedge clock);
            stall_i = 1'b0;
            wait_insts(1);
        end
        wait_insts(4);
        repeat (4) @(negedge clock);
        $display("errors %0d, instructions %0d, AR reads %0d, cycles %0d",
                 err_count, delivered, ar_reads, cycles);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
